//--- ppu_pkg.sv
package ppu_pkg;

  // ========================================
  // Line and frame timing
  // ========================================

  // Dots in one scanline
  localparam logic [8:0] dots_per_line = 9'd456;
  // Lines per frame, VBlank lines included
  localparam logic [7:0] lines_per_frame = 8'd154;
  // Visible lines
  localparam logic [7:0] screen_height = 8'd144;
  // Visible pixels per line
  localparam logic [7:0] screen_width = 8'd160;
  // Fixed wait standing in for the OAM scan
  localparam logic [8:0] mode2_len = 9'd80;

  // ========================================
  // CPU address map
  // ========================================

  // 8 KB video RAM window
  localparam logic [15:0] vram_start = 16'h8000;
  localparam logic [15:0] vram_end = 16'h9FFF;

  // LCD registers, FF46 (DMA) not present
  localparam logic [15:0] reg_lcdc = 16'hFF40;
  localparam logic [15:0] reg_stat = 16'hFF41;
  localparam logic [15:0] reg_scy = 16'hFF42;
  localparam logic [15:0] reg_scx = 16'hFF43;
  localparam logic [15:0] reg_ly = 16'hFF44;
  localparam logic [15:0] reg_lyc = 16'hFF45;
  localparam logic [15:0] reg_bgp = 16'hFF47;

  // Background pixel FIFO
  localparam int fifo_depth = 16;
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  // Fetcher steps
  localparam logic [1:0] fetch_map = 2'd0;
  localparam logic [1:0] fetch_lo = 2'd1;
  localparam logic [1:0] fetch_hi = 2'd2;
  localparam logic [1:0] fetch_push = 2'd3;

  // Same encoding as STAT bits 1:0
  typedef enum logic [1:0] {
    mode_hblank = 2'd0,
    mode_vblank = 2'd1,
    mode_oam    = 2'd2,
    mode_xfer   = 2'd3
  } ppu_mode_t;

  // LCDC seen as bus byte or as control flags
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic lcd_en;
      logic win_map;
      logic win_en;
      logic tile_data_sel;
      logic bg_map_sel;
      logic obj_size;
      logic obj_en;
      logic bg_en;
    } flags;
  } lcdc_t;

endpackage

//--- ppu_regs.sv
module ppu_regs (
  input  logic               clk,
  input  logic               reset,
  input  logic [15:0]        addr,
  input  logic [7:0]         wdata,
  input  logic               write_en,
  input  logic               read_en,
  output logic [7:0]         rdata,
  input  ppu_pkg::ppu_mode_t mode,
  input  logic [7:0]         ly,
  input  logic               coincidence,
  input  logic [12:0]        vram_addr,
  output logic [7:0]         vram_data,
  output ppu_pkg::lcdc_t     lcdc,
  output logic [7:0]         scx,
  output logic [7:0]         scy,
  output logic [7:0]         lyc,
  output logic [7:0]         bgp,
  output logic [3:0]         stat_en
);
  import ppu_pkg::*;

  logic [7:0] vram [int'(vram_end - vram_start) + 1];
  logic       vram_sel;
  logic       vram_open;

  // ========================================
  // Address decode
  // ========================================
  assign vram_sel = (addr >= vram_start) && (addr <= vram_end);
  // CPU locked out of VRAM while pixels are drawn
  assign vram_open = (mode != mode_xfer);

  // VRAM write port, CPU side only
  always_ff @(posedge clk) begin
    if (write_en && vram_sel && vram_open) begin
      vram[addr[12:0]] <= wdata;
    end
  end

  // Fetcher read port, never blocked
  assign vram_data = vram[vram_addr];

  // Register file
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lcdc.raw <= 8'h00;
      stat_en  <= 4'h0;
      scy      <= 8'h00;
      scx      <= 8'h00;
      lyc      <= 8'h00;
      bgp      <= 8'h00;
    end else if (write_en && !vram_sel) begin
      case (addr)
        reg_lcdc: lcdc.raw <= wdata;
        // Interrupt enables only, rest of STAT is status
        reg_stat: stat_en <= wdata[6:3];
        reg_scy:  scy <= wdata;
        reg_scx:  scx <= wdata;
        // LY is read only
        reg_lyc:  lyc <= wdata;
        reg_bgp:  bgp <= wdata;
        default:  ;
      endcase
    end
  end

  // ========================================
  // CPU read mux
  // ========================================
  always_comb begin
    // Open bus default
    rdata = 8'hFF;
    if (read_en) begin
      if (vram_sel) begin
        if (vram_open) begin
          rdata = vram[addr[12:0]];
        end
      end else begin
        case (addr)
          reg_lcdc: rdata = lcdc.raw;
          // Bit 7 reads as 1
          reg_stat: rdata = {1'b1, stat_en, coincidence, mode};
          reg_scy:  rdata = scy;
          reg_scx:  rdata = scx;
          reg_ly:   rdata = ly;
          reg_lyc:  rdata = lyc;
          reg_bgp:  rdata = bgp;
          // WY, WX and unmapped addresses
          default:  rdata = 8'hFF;
        endcase
      end
    end
  end

endmodule

//--- ppu_timing.sv
module ppu_timing (
  input  logic               clk,
  input  logic               reset,
  input  ppu_pkg::lcdc_t     lcdc,
  input  logic [7:0]         lyc,
  input  logic [3:0]         stat_en,
  input  logic               line_done,
  output ppu_pkg::ppu_mode_t mode,
  output logic [7:0]         ly,
  output logic               coincidence,
  output logic               flush,
  output logic               vblank_req,
  output logic               stat_req
);
  import ppu_pkg::*;

  logic [8:0] dot;
  logic       line_end;
  logic [7:0] ly_prev;
  ppu_mode_t  mode_prev;
  logic       lyc_hit;
  logic       mode_hit;

  assign line_end    = (dot == dots_per_line - 9'd1);
  assign coincidence = (ly == lyc);

  // ========================================
  // Dot and line counters
  // ========================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot <= 9'd0;
      ly  <= 8'd0;
    end else if (!lcdc.flags.lcd_en) begin
      // Held at top of frame while display is off
      dot <= 9'd0;
      ly  <= 8'd0;
    end else if (line_end) begin
      dot <= 9'd0;
      ly  <= (ly == lines_per_frame - 8'd1) ? 8'd0 : ly + 8'd1;
    end else begin
      dot <= dot + 9'd1;
    end
  end

  // ========================================
  // Mode state machine
  // ========================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode  <= mode_oam;
      flush <= 1'b0;
    end else begin
      flush <= 1'b0;
      if (!lcdc.flags.lcd_en) begin
        mode <= mode_oam;
      end else if (line_end) begin
        // Next line decides the mode, also ends a stuck transfer
        if (ly == screen_height - 8'd1) begin
          mode <= mode_vblank;
        end else if (ly == lines_per_frame - 8'd1) begin
          mode <= mode_oam;
        end else if (mode != mode_vblank) begin
          mode <= mode_oam;
        end
      end else begin
        case (mode)
          mode_oam: begin
            if (dot == mode2_len - 9'd1) begin
              // Restart fetcher and FIFO with the transfer
              mode  <= mode_xfer;
              flush <= 1'b1;
            end
          end
          mode_xfer: begin
            if (line_done) begin
              mode <= mode_hblank;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // ========================================
  // Interrupt requests
  // ========================================
  // STAT enables 6:3 map to stat_en 3:0
  assign lyc_hit  = stat_en[3] && coincidence && (ly != ly_prev);
  assign mode_hit = (mode != mode_prev) &&
                    ((stat_en[2] && mode == mode_oam) ||
                     (stat_en[1] && mode == mode_vblank) ||
                     (stat_en[0] && mode == mode_hblank));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ly_prev    <= 8'd0;
      mode_prev  <= mode_oam;
      vblank_req <= 1'b0;
      stat_req   <= 1'b0;
    end else begin
      ly_prev    <= ly;
      mode_prev  <= mode;
      // Entry into line 144, one pulse per frame
      vblank_req <= lcdc.flags.lcd_en && (ly == screen_height) &&
                    (ly_prev == screen_height - 8'd1);
      // No requests while the display is off
      stat_req   <= lcdc.flags.lcd_en && (lyc_hit || mode_hit);
    end
  end

endmodule

//--- bg_fetcher.sv
module bg_fetcher (
  input  logic               clk,
  input  logic               reset,
  input  logic               flush,
  input  ppu_pkg::ppu_mode_t mode,
  input  ppu_pkg::lcdc_t     lcdc,
  input  logic [7:0]         scx,
  input  logic [7:0]         scy,
  input  logic [7:0]         ly,
  input  logic [4:0]         count,
  input  logic [7:0]         vram_data,
  output logic [12:0]        vram_addr,
  output logic               push,
  output logic [15:0]        push_pixels
);
  import ppu_pkg::*;

  logic [1:0]  state;
  logic [4:0]  tile_cnt;
  logic [7:0]  tile_idx;
  logic [7:0]  data_lo;
  logic [7:0]  data_hi;
  logic        active;
  logic [7:0]  bg_line;
  logic [4:0]  map_col;
  logic [12:0] map_addr;
  logic [11:0] row_addr;

  assign active  = (mode == mode_xfer) && !flush;
  // Background line after vertical scroll, wraps at 256
  assign bg_line = ly + scy;
  // Tile column wraps at 32
  assign map_col = scx[7:3] + tile_cnt;
  // Map at 9800 or 9C00
  assign map_addr = {2'b11, lcdc.flags.bg_map_sel, bg_line[7:3], map_col};
  // 8000 unsigned, or 9000 based with signed index
  assign row_addr = {~lcdc.flags.tile_data_sel & ~tile_idx[7], tile_idx, bg_line[2:0]};

  // Room for a whole tile row
  assign push = active && (state == fetch_push) && (count <= 5'd8);

  always_comb begin
    case (state)
      fetch_lo: vram_addr = {row_addr, 1'b0};
      fetch_hi: vram_addr = {row_addr, 1'b1};
      default:  vram_addr = map_addr;
    endcase
  end

  // Step sequencer
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= fetch_map;
      tile_cnt <= 5'd0;
    end else if (flush) begin
      state    <= fetch_map;
      tile_cnt <= 5'd0;
    end else if (active) begin
      case (state)
        fetch_map: state <= fetch_lo;
        fetch_lo:  state <= fetch_hi;
        fetch_hi:  state <= fetch_push;
        default: begin
          // Wait here while the FIFO is too full
          if (push) begin
            state    <= fetch_map;
            tile_cnt <= tile_cnt + 5'd1;
          end
        end
      endcase
    end
  end

  // Fetched bytes
  always_ff @(posedge clk) begin
    if (active) begin
      case (state)
        fetch_map: tile_idx <= vram_data;
        fetch_lo:  data_lo <= vram_data;
        fetch_hi:  data_hi <= vram_data;
        default:   ;
      endcase
    end
  end

  // Leftmost pixel from bit 7, first out in bits 1:0
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      push_pixels[2*i +: 2] = lcdc.flags.bg_en ? {data_hi[7-i], data_lo[7-i]} : 2'b00;
    end
  end

endmodule

//--- pixel_fifo.sv
module pixel_fifo (
  input  logic        clk,
  input  logic        reset,
  input  logic        flush,
  input  logic        push,
  input  logic [15:0] push_pixels,
  input  logic        pop,
  output logic [1:0]  pop_pixel,
  output logic [4:0]  count,
  output logic        empty
);
  import ppu_pkg::*;

  logic [1:0]            mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic                  do_pop;

  assign empty     = (count == 5'd0);
  // Pop on empty is ignored
  assign do_pop    = pop && !empty;
  assign pop_pixel = mem[rd_ptr];

  // Pointers and fill level, flush wins
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 5'd0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 5'd0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + fifo_ptr_w'(8);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + fifo_ptr_w'(1);
      end
      count <= count + (push ? 5'd8 : 5'd0) - (do_pop ? 5'd1 : 5'd0);
    end
  end

  // Eight entries per push, wrapping
  always_ff @(posedge clk) begin
    if (push && !flush) begin
      for (int i = 0; i < 8; i++) begin
        mem[wr_ptr + fifo_ptr_w'(i)] <= push_pixels[2*i +: 2];
      end
    end
  end

endmodule

//--- pixel_output.sv
module pixel_output (
  input  logic               clk,
  input  logic               reset,
  input  logic               flush,
  input  ppu_pkg::ppu_mode_t mode,
  input  logic [7:0]         scx,
  input  logic [7:0]         bgp,
  input  logic [7:0]         ly,
  input  logic               empty,
  input  logic [1:0]         pop_pixel,
  output logic               pop,
  output logic               pixel_valid,
  output logic [1:0]         pixel_color,
  output logic [7:0]         pixel_x,
  output logic [7:0]         pixel_y,
  output logic               line_done
);
  import ppu_pkg::*;

  logic [7:0] x_cnt;
  logic [2:0] drop_cnt;
  logic       dropping;

  // Drain whatever is ready until the line is full
  assign pop      = (mode == mode_xfer) && !flush && !empty && (x_cnt < screen_width);
  // Fine scroll, first SCX mod 8 pixels thrown away
  assign dropping = (drop_cnt < scx[2:0]);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x_cnt       <= screen_width;
      drop_cnt    <= 3'd0;
      pixel_valid <= 1'b0;
      line_done   <= 1'b0;
    end else begin
      pixel_valid <= 1'b0;
      // One cycle after the last pixel of the line
      line_done   <= pixel_valid && (pixel_x == screen_width - 8'd1);
      if (flush) begin
        x_cnt    <= 8'd0;
        drop_cnt <= 3'd0;
      end else if (pop) begin
        if (dropping) begin
          drop_cnt <= drop_cnt + 3'd1;
        end else begin
          pixel_valid <= 1'b1;
          x_cnt       <= x_cnt + 8'd1;
        end
      end
    end
  end

  // Shade through BGP, index n selects bits 2n+1:2n
  always_ff @(posedge clk) begin
    if (pop && !dropping) begin
      pixel_color <= bgp[{pop_pixel, 1'b0} +: 2];
      pixel_x     <= x_cnt;
      pixel_y     <= ly;
    end
  end

endmodule

//--- ppu_top.sv
module ppu_top (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] addr,
  input  logic [7:0]  wdata,
  input  logic        write_en,
  input  logic        read_en,
  output logic [7:0]  rdata,
  output logic        pixel_valid,
  output logic [1:0]  pixel_color,
  output logic [7:0]  pixel_x,
  output logic [7:0]  pixel_y,
  output logic        vblank_req,
  output logic        stat_req
);
  import ppu_pkg::*;

  // Register outputs
  lcdc_t       lcdc;
  logic [7:0]  scx;
  logic [7:0]  scy;
  logic [7:0]  lyc;
  logic [7:0]  bgp;
  logic [3:0]  stat_en;
  // Timing outputs
  ppu_mode_t   mode;
  logic [7:0]  ly;
  logic        coincidence;
  logic        flush;
  logic        line_done;
  // Fetch path
  logic [12:0] vram_addr;
  logic [7:0]  vram_data;
  logic        push;
  logic [15:0] push_pixels;
  logic [4:0]  count;
  logic        pop;
  logic [1:0]  pop_pixel;
  logic        empty;

  ppu_regs regs_i (
    .clk        (clk),
    .reset      (reset),
    .addr       (addr),
    .wdata      (wdata),
    .write_en   (write_en),
    .read_en    (read_en),
    .rdata      (rdata),
    .mode       (mode),
    .ly         (ly),
    .coincidence(coincidence),
    .vram_addr  (vram_addr),
    .vram_data  (vram_data),
    .lcdc       (lcdc),
    .scx        (scx),
    .scy        (scy),
    .lyc        (lyc),
    .bgp        (bgp),
    .stat_en    (stat_en)
  );

  ppu_timing timing_i (
    .clk        (clk),
    .reset      (reset),
    .lcdc       (lcdc),
    .lyc        (lyc),
    .stat_en    (stat_en),
    .line_done  (line_done),
    .mode       (mode),
    .ly         (ly),
    .coincidence(coincidence),
    .flush      (flush),
    .vblank_req (vblank_req),
    .stat_req   (stat_req)
  );

  bg_fetcher fetcher_i (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .mode       (mode),
    .lcdc       (lcdc),
    .scx        (scx),
    .scy        (scy),
    .ly         (ly),
    .count      (count),
    .vram_data  (vram_data),
    .vram_addr  (vram_addr),
    .push       (push),
    .push_pixels(push_pixels)
  );

  pixel_fifo fifo_i (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .push       (push),
    .push_pixels(push_pixels),
    .pop        (pop),
    .pop_pixel  (pop_pixel),
    .count      (count),
    .empty      (empty)
  );

  pixel_output output_i (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .mode       (mode),
    .scx        (scx),
    .bgp        (bgp),
    .ly         (ly),
    .empty      (empty),
    .pop_pixel  (pop_pixel),
    .pop        (pop),
    .pixel_valid(pixel_valid),
    .pixel_color(pixel_color),
    .pixel_x    (pixel_x),
    .pixel_y    (pixel_y),
    .line_done  (line_done)
  );

endmodule

//--- ppu_assert.sv
module ppu_timing_assert (
  input logic               clk,
  input logic               reset,
  input logic [8:0]         dot,
  input logic               vblank_req,
  input ppu_pkg::ppu_mode_t mode,
  input logic               lcd_en
);
  timeunit 1ns;
  timeprecision 1ps;
  import ppu_pkg::*;

  // Number of failed assertions so far
  int fail_count = 0;

  // VBlank request is a single-cycle pulse
  vblank_one_cycle: assert property (@(posedge clk) disable iff (reset)
    vblank_req |=> !vblank_req)
    else begin
      $error("vblank_req stayed high for more than one cycle");
      fail_count++;
    end

  // Dot counter wraps before 456
  dot_in_range: assert property (@(posedge clk) disable iff (reset)
    dot < dots_per_line)
    else begin
      $error("dot counter went past the end of the line");
      fail_count++;
    end

  // Display off forces the OAM mode one edge later
  oam_while_off: assert property (@(posedge clk) disable iff (reset)
    !lcd_en |=> (mode == mode_oam))
    else begin
      $error("mode left mode_oam while the LCD was disabled");
      fail_count++;
    end

endmodule

bind ppu_timing ppu_timing_assert timing_assert_i (
  .clk       (clk),
  .reset     (reset),
  .dot       (dot),
  .vblank_req(vblank_req),
  .mode      (mode),
  .lcd_en    (lcdc.flags.lcd_en)
);

//--- tb_ppu.sv
module tb_ppu;
  timeunit 1ns;
  timeprecision 1ps;
  import ppu_pkg::*;

  logic        clk;
  logic        reset;
  logic [15:0] addr;
  logic [7:0]  wdata;
  logic        write_en;
  logic        read_en;
  logic [7:0]  rdata;
  logic        pixel_valid;
  logic [1:0]  pixel_color;
  logic [7:0]  pixel_x;
  logic [7:0]  pixel_y;
  logic        vblank_req;
  logic        stat_req;

  // Testbench copy of VRAM and of the render registers
  logic [7:0]  vram_copy [8192];
  logic [7:0]  scx_v;
  logic [7:0]  scy_v;
  logic [7:0]  bgp_v;
  logic [7:0]  lcdc_v;
  logic [7:0]  lyc_v;
  logic [31:0] seed;
  // Pixel checker state
  logic        check_pixels;
  int          exp_x;
  int          exp_y;
  int          lines_seen;
  // Event counters
  int          stat_cnt;
  int          both_cnt;
  int          cycle;
  // Main sequence scratch
  logic [7:0]  rd;
  int          t0;
  int          a;
  int          n;

  ppu_top dut_i (
    .clk        (clk),
    .reset      (reset),
    .addr       (addr),
    .wdata      (wdata),
    .write_en   (write_en),
    .read_en    (read_en),
    .rdata      (rdata),
    .pixel_valid(pixel_valid),
    .pixel_color(pixel_color),
    .pixel_x    (pixel_x),
    .pixel_y    (pixel_y),
    .vblank_req (vblank_req),
    .stat_req   (stat_req)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ========================================
  // Helpers
  // ========================================

  // LCG step, middle bits as the random byte
  function automatic logic [7:0] rand_byte();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[23:16];
  endfunction

  // Expected shade at screen (x, y)
  function automatic logic [1:0] ref_pixel(input int x, input int y);
    int bx;
    int by;
    int map_addr;
    int idx;
    int row_base;
    logic [7:0] lo;
    logic [7:0] hi;
    logic [1:0] ci;
    // Scroll wraps the 256x256 background
    bx = (x + scx_v) % 256;
    by = (y + scy_v) % 256;
    // 32x32 map at 9800 or 9C00
    map_addr = 'h1800 + (lcdc_v[3] ? 'h400 : 0) + (by / 8) * 32 + bx / 8;
    idx = vram_copy[map_addr];
    // 8000 unsigned, or 9000 plus signed index
    if (lcdc_v[4]) begin
      row_base = idx * 16;
    end else begin
      row_base = 'h1000 + ((idx >= 128) ? idx - 256 : idx) * 16;
    end
    lo = vram_copy[row_base + (by % 8) * 2];
    hi = vram_copy[row_base + (by % 8) * 2 + 1];
    // Bit 7 is the leftmost pixel
    ci = lcdc_v[0] ? {hi[7 - bx % 8], lo[7 - bx % 8]} : 2'b00;
    return bgp_v[2 * ci +: 2];
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check(input string test, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("FAILED %s expected %0h actual %0h", test, expected, actual));
    end
  endtask

  // One write cycle, lands on the second edge
  task automatic bus_write(input logic [15:0] a_in, input logic [7:0] d_in);
    @(posedge clk);
    addr     <= a_in;
    wdata    <= d_in;
    write_en <= 1'b1;
    @(posedge clk);
    write_en <= 1'b0;
  endtask

  // rdata is combinational, sampled mid-cycle
  task automatic bus_read(input logic [15:0] a_in, output logic [7:0] d_out);
    @(posedge clk);
    addr    <= a_in;
    read_en <= 1'b1;
    @(negedge clk);
    d_out = rdata;
    @(posedge clk);
    read_en <= 1'b0;
  endtask

  // Poll STAT until the mode field matches, up to about one frame
  task automatic wait_mode(input logic [1:0] m);
    logic [7:0] s;
    int polls;
    polls = 0;
    bus_read(reg_stat, s);
    while (s[1:0] != m) begin
      if (polls == 40000) begin
        fail_run($sformatf("timed out waiting for STAT mode %0d", m));
      end else begin
        polls++;
        bus_read(reg_stat, s);
      end
    end
  endtask

  // Returns at the negedge of the pulse cycle
  task automatic wait_irq(input bit use_stat);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!(use_stat ? stat_req : vblank_req)) begin
      if (waited == 80000) begin
        fail_run(use_stat ? "timed out waiting for stat_req" :
                            "timed out waiting for vblank_req");
      end else begin
        waited++;
        @(negedge clk);
      end
    end
  endtask

  // ========================================
  // Monitors
  // ========================================

  // Flop outputs read before the edge updates them
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (stat_req) begin
      stat_cnt++;
    end
    if (stat_req && vblank_req) begin
      both_cnt++;
    end
  end

  // Bound timing assertions
  always @(negedge clk) begin
    if (dut_i.timing_i.timing_assert_i.fail_count != 0) begin
      fail_run("a timing assertion on the PPU failed");
    end
  end

  // Pixel stream against the reference
  always @(negedge clk) begin
    if (pixel_valid && check_pixels) begin
      check($sformatf("pixel_x at line %0d", exp_y), exp_x, pixel_x);
      check($sformatf("pixel_y at x %0d", exp_x), exp_y, pixel_y);
      check($sformatf("pixel (%0d,%0d)", exp_x, exp_y),
            ref_pixel(exp_x, exp_y), pixel_color);
      if (exp_x == 159) begin
        exp_x = 0;
        exp_y = (exp_y == 143) ? 0 : exp_y + 1;
        lines_seen++;
      end else begin
        exp_x++;
      end
    end
  end

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    reset        = 1'b1;
    addr         = 16'h0000;
    wdata        = 8'h00;
    write_en     = 1'b0;
    read_en      = 1'b0;
    seed         = 32'h01e2_9326;
    check_pixels = 1'b0;
    exp_x        = 0;
    exp_y        = 0;
    lines_seen   = 0;
    stat_cnt     = 0;
    both_cnt     = 0;
    cycle        = 0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // Register readback, LCD still off
    scy_v = rand_byte();
    scx_v = rand_byte();
    lyc_v = rand_byte();
    bgp_v = rand_byte();
    bus_write(reg_scy, scy_v);
    bus_write(reg_scx, scx_v);
    bus_write(reg_lyc, lyc_v);
    bus_write(reg_bgp, bgp_v);
    bus_read(reg_scy, rd);
    check("scy readback", scy_v, rd);
    bus_read(reg_scx, rd);
    check("scx readback", scx_v, rd);
    bus_read(reg_lyc, rd);
    check("lyc readback", lyc_v, rd);
    bus_read(reg_bgp, rd);
    check("bgp readback", bgp_v, rd);
    lcdc_v = rand_byte() & 8'h7F;
    bus_write(reg_lcdc, lcdc_v);
    bus_read(reg_lcdc, rd);
    check("lcdc readback", lcdc_v, rd);
    // Only enables stick, LY is 0 and mode is 2 while off
    bus_write(reg_stat, 8'hFF);
    bus_read(reg_stat, rd);
    check("stat readback", {1'b1, 4'hF, lyc_v == 8'd0, 2'd2}, rd);
    bus_write(reg_stat, 8'h00);
    // WY is not implemented
    bus_read(16'hFF4A, rd);
    check("wy readback", 8'hFF, rd);
    bus_write(reg_ly, 8'h55);
    bus_read(reg_ly, rd);
    check("ly write ignored", 8'h00, rd);

    // Fill all of VRAM and read it back
    for (a = 0; a < 8192; a++) begin
      vram_copy[a] = rand_byte();
      bus_write(vram_start + 16'(a), vram_copy[a]);
    end
    for (a = 0; a < 8192; a++) begin
      bus_read(vram_start + 16'(a), rd);
      check($sformatf("vram readback %0h", a), vram_copy[a], rd);
    end

    // Two rendering rounds, one per tile data mode
    for (int r = 0; r < 2; r++) begin
      scx_v  = rand_byte();
      scy_v  = rand_byte();
      bgp_v  = rand_byte();
      lcdc_v = 8'h81 | (8'(r) << 4) | ((rand_byte() & 8'h01) << 3);
      bus_write(reg_scx, scx_v);
      bus_write(reg_scy, scy_v);
      bus_write(reg_bgp, bgp_v);
      exp_x        = 0;
      exp_y        = 0;
      lines_seen   = 0;
      check_pixels = 1'b1;
      bus_write(reg_lcdc, lcdc_v);
      // Two full frames of visible lines
      n = 0;
      while (lines_seen < 288) begin
        if (n == 150000) begin
          fail_run("pixel stream stopped before two frames were drawn");
        end else begin
          n++;
          @(posedge clk);
        end
      end
      check_pixels = 1'b0;
      if (r == 0) begin
        // VRAM locked during mode 3, open again in HBlank
        a = {rand_byte(), rand_byte()} % 8192;
        // A stored FF would look like a blocked read
        while (vram_copy[a] == 8'hFF) begin
          a = (a + 1) % 8192;
        end
        wait_mode(2'd0);
        wait_mode(2'd3);
        bus_read(vram_start + 16'(a), rd);
        check("vram read in mode 3", 8'hFF, rd);
        bus_write(vram_start + 16'(a), ~vram_copy[a]);
        wait_mode(2'd0);
        bus_read(vram_start + 16'(a), rd);
        check("vram write in mode 3 dropped", vram_copy[a], rd);
      end
      bus_write(reg_lcdc, lcdc_v & 8'h7F);
    end

    // Frame period between VBlank pulses
    bus_write(reg_lcdc, lcdc_v);
    wait_irq(1'b0);
    t0 = cycle;
    wait_irq(1'b0);
    check("frame period", 70224, cycle - t0);
    bus_read(reg_ly, rd);
    check("ly after vblank", 8'd144, rd);

    // LYC interrupt, one per frame
    lyc_v = rand_byte() % 154;
    bus_write(reg_lyc, lyc_v);
    bus_write(reg_stat, 8'h40);
    wait_irq(1'b0);
    stat_cnt = 0;
    wait_irq(1'b0);
    check("lyc stat per frame", 1, stat_cnt);
    wait_irq(1'b1);
    bus_read(reg_ly, rd);
    check("ly at lyc stat", lyc_v, rd);

    // Mode 1 interrupt lines up with VBlank
    bus_write(reg_stat, 8'h10);
    wait_irq(1'b0);
    stat_cnt = 0;
    both_cnt = 0;
    wait_irq(1'b0);
    check("vblank stat per frame", 1, stat_cnt);
    check("vblank stat with vblank_req", 1, both_cnt);

    // Display off with every STAT source enabled
    bus_write(reg_stat, 8'h78);
    bus_write(reg_lcdc, lcdc_v & 8'h7F);
    bus_read(reg_ly, rd);
    check("ly with lcd off", 8'd0, rd);
    bus_read(reg_stat, rd);
    check("stat mode with lcd off", 2'd2, rd[1:0]);
    for (n = 0; n < 456; n++) begin
      @(negedge clk);
      if (pixel_valid || vblank_req || stat_req) begin
        fail_run("pixel or interrupt activity while the LCD is disabled");
      end
    end

    if (dut_i.timing_i.timing_assert_i.fail_count != 0) begin
      fail_run("a timing assertion on the PPU failed");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

//--- src.f
ppu_pkg.sv
ppu_regs.sv
ppu_timing.sv
bg_fetcher.sv
pixel_fifo.sv
pixel_output.sv
ppu_top.sv
ppu_assert.sv
tb_ppu.sv
